// File: hdl/sdram_pkg.sv
/* sdram_pkg
   widths, timing and command encodings for the SDR SDRAM front end
   (32-bit chip, 4 banks, 11 row bits, 8 column bits) */
package sdram_pkg;

    typedef logic [20:0] word_addr_t;   // bank[20:19] row[18:8] col[7:0]
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;   // 1 = byte gets written
    typedef logic [10:0] sdram_addr_t;
    typedef logic [1:0]  bank_t;

    localparam int CLK_PERIOD_NS    = 40;
    localparam int INIT_WAIT_CYCLES = 5000;  // 200 us power-up wait at 25 MHz
    localparam int T_RP_CYCLES      = 1;
    localparam int T_RCD_CYCLES     = 1;
    localparam int T_RFC_CYCLES     = 2;
    localparam int T_WR_CYCLES      = 2;     // write recovery plus auto-precharge
    localparam int CAS_LATENCY      = 2;

    // single location write, CL2, sequential, burst length 1
    localparam sdram_addr_t MODE_REG_VALUE = 11'h220;

    // command pins as {ncs, nras, ncas, nwe}
    localparam logic [3:0] CMD_NOP       = 4'b0111;
    localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [3:0] CMD_READ      = 4'b0101;
    localparam logic [3:0] CMD_WRITE     = 4'b0100;
    localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [3:0] CMD_REFRESH   = 4'b0001;
    localparam logic [3:0] CMD_MRS       = 4'b0000;

    typedef enum logic [3:0] {
        init_wait,
        init_pre,
        init_ref,
        init_mrs,
        idle,
        activate,
        rw_cmd,
        read_wait,
        write_rec,
        refresh_wait
    } drv_state_t;

endpackage

// File: hdl/sdram_cmd_if.sv
`timescale 1ns/1ps

/* sdram_cmd_if
   one command and its response between memory controller and SDRAM driver */
interface sdram_cmd_if import sdram_pkg::*; ();

    logic       rd;          // one-cycle pulses, only while busy is low
    logic       wr;
    logic       refresh;
    word_addr_t addr;
    word_t      din;
    byte_mask_t mask;

    word_t      dout;
    logic       busy;
    logic       data_ready;  // dout valid for exactly this cycle

    modport controller (
        output rd, wr, refresh, addr, din, mask,
        input  dout, busy, data_ready
    );

    modport driver (
        input  rd, wr, refresh, addr, din, mask,
        output dout, busy, data_ready
    );

endinterface

// File: hdl/sdram_driver.sv
`timescale 1ns/1ps

/* sdram_driver
   SDR SDRAM sequencer: power-up init, then per command either ACTIVE plus
   READ/WRITE with auto-precharge, or AUTO REFRESH. Owns the DQ tristate */
module sdram_driver import sdram_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    sdram_cmd_if.driver   cmd,
    inout  wire word_t    sdram_dq,
    output sdram_addr_t   sdram_a,
    output bank_t         sdram_ba,
    output logic          sdram_ncs,
    output logic          sdram_nras,
    output logic          sdram_ncas,
    output logic          sdram_nwe,
    output logic          sdram_cke,
    output logic          sdram_clk,
    output logic [3:0]    sdram_dqm
);

    drv_state_t  state;
    logic [12:0] cnt;          // holds the longest wait, the power-up delay
    logic        second_ref;   // init has already issued one refresh
    logic        is_wr;
    logic [7:0]  col;
    word_t       wr_data;
    byte_mask_t  wr_mask;
    logic [3:0]  sdram_cmd;
    logic        dq_oe;
    word_t       dq_out;

    assign sdram_clk = ~clk;   // chip samples at mid-cycle
    assign sdram_cke = 1'b1;
    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = sdram_cmd;
    assign sdram_dq  = dq_oe ? dq_out : 'z;

    always_ff @(posedge clk) begin
        sdram_cmd      <= CMD_NOP;
        dq_oe          <= 1'b0;
        cmd.data_ready <= 1'b0;
        if (!resetn) begin
            state      <= init_wait;
            cnt        <= 13'(INIT_WAIT_CYCLES - 1);
            second_ref <= 1'b0;
            cmd.busy   <= 1'b1;
            sdram_a    <= '0;
            sdram_ba   <= '0;
            sdram_dqm  <= 4'hf;   // outputs masked until the chip is set up
        end else begin
            if (cnt != '0)
                cnt <= cnt - 13'd1;

            case (state)
                init_wait: begin
                    if (cnt == '0) begin
                        sdram_cmd <= CMD_PRECHARGE;
                        sdram_a   <= 11'h400;   // A10 high, all banks
                        cnt       <= 13'(T_RP_CYCLES - 1);
                        state     <= init_pre;
                    end
                end
                init_pre: begin
                    if (cnt == '0) begin
                        sdram_cmd  <= CMD_REFRESH;
                        cnt        <= 13'(T_RFC_CYCLES - 1);
                        second_ref <= 1'b0;
                        state      <= init_ref;
                    end
                end
                init_ref: begin
                    if (cnt == '0) begin
                        if (!second_ref) begin
                            sdram_cmd  <= CMD_REFRESH;
                            cnt        <= 13'(T_RFC_CYCLES - 1);
                            second_ref <= 1'b1;
                        end else begin
                            sdram_cmd <= CMD_MRS;
                            sdram_a   <= MODE_REG_VALUE;
                            sdram_ba  <= '0;
                            state     <= init_mrs;
                        end
                    end
                end
                init_mrs: begin
                    // idle NOP cycle plus controller turnaround covers tMRD
                    cmd.busy <= 1'b0;
                    state    <= idle;
                end
                idle: begin
                    if (cmd.rd || cmd.wr) begin
                        sdram_cmd <= CMD_ACTIVE;
                        sdram_ba  <= cmd.addr[20:19];
                        sdram_a   <= cmd.addr[18:8];   // row
                        sdram_dqm <= 4'h0;
                        col       <= cmd.addr[7:0];
                        wr_data   <= cmd.din;
                        wr_mask   <= cmd.mask;
                        is_wr     <= cmd.wr;
                        cmd.busy  <= 1'b1;
                        cnt       <= 13'(T_RCD_CYCLES - 1);
                        state     <= activate;
                    end else if (cmd.refresh) begin
                        sdram_cmd <= CMD_REFRESH;
                        cmd.busy  <= 1'b1;
                        cnt       <= 13'(T_RFC_CYCLES - 1);
                        state     <= refresh_wait;
                    end
                end
                activate: begin
                    if (cnt == '0) begin
                        sdram_a <= {1'b1, 2'b00, col};   // A10 = auto-precharge
                        if (is_wr) begin
                            sdram_cmd <= CMD_WRITE;
                            dq_oe     <= 1'b1;
                            dq_out    <= wr_data;
                            sdram_dqm <= ~wr_mask;
                        end else begin
                            sdram_cmd <= CMD_READ;
                        end
                        state <= rw_cmd;
                    end
                end
                rw_cmd: begin
                    sdram_dqm <= 4'h0;
                    if (is_wr) begin
                        cnt   <= 13'(T_WR_CYCLES - 1);
                        state <= write_rec;
                    end else begin
                        cnt   <= 13'(CAS_LATENCY - 1);
                        state <= read_wait;
                    end
                end
                read_wait: begin
                    if (cnt == '0) begin
                        cmd.dout       <= sdram_dq;   // data valid at the CL edge
                        cmd.data_ready <= 1'b1;
                        cmd.busy       <= 1'b0;
                        state          <= idle;
                    end
                end
                write_rec, refresh_wait: begin
                    if (cnt == '0) begin
                        cmd.busy <= 1'b0;
                        state    <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: hdl/memory_controller.sv
`timescale 1ns/1ps

/* memory_controller
   single-command user port over the SDRAM driver: two read flavors with their
   own data registers, masked write, refresh, busy, fail flag and write count */
module memory_controller import sdram_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            read_a,
    input  logic            read_b,
    input  logic            write,
    input  logic            refresh,
    input  word_addr_t      addr,
    input  word_t           din,
    input  byte_mask_t      mask,
    output word_t           dout_a,
    output word_t           dout_b,
    output logic            busy,
    output logic            mem_initialized,
    output logic            fail,
    output logic [19:0]     total_written,
    sdram_cmd_if.controller mem
);

    logic       want_read;
    logic       accept;
    logic [2:0] cycles;     // cycles since acceptance, saturates at 7
    logic       is_read;
    logic       is_write;
    logic       r_read_a;   // flavors requested by the read in flight
    logic       r_read_b;
    logic       op_done;
    word_t      da;
    word_t      db;

    assign want_read = read_a || read_b;
    assign accept    = !busy && (want_read || write || refresh);

    // passed straight through while idle, driver samples on the accepting edge
    assign mem.rd      = !busy && want_read;
    assign mem.wr      = !busy && write && !want_read;
    assign mem.refresh = !busy && refresh && !want_read && !write;
    assign mem.addr    = addr;
    assign mem.din     = din;
    assign mem.mask    = mask;

    // read and refresh have fixed latency, write waits for the driver
    assign op_done = is_write ? (cycles >= 3'd5 && !mem.busy) : (cycles == 3'd4);

    // bypass so the new word shows in the same cycle it is latched
    assign dout_a = (cycles == 3'd4 && r_read_a) ? mem.dout : da;
    assign dout_b = (cycles == 3'd4 && r_read_b) ? mem.dout : db;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy            <= 1'b1;
            mem_initialized <= 1'b0;
            fail            <= 1'b0;
            total_written   <= '0;
            cycles          <= 3'd7;
            is_read         <= 1'b0;
            is_write        <= 1'b0;
            r_read_a        <= 1'b0;
            r_read_b        <= 1'b0;
        end else if (!busy) begin
            if (accept) begin
                busy     <= 1'b1;
                cycles   <= 3'd0;
                is_read  <= want_read;
                is_write <= write && !want_read;
                r_read_a <= read_a;
                r_read_b <= read_b;
            end
        end else if (!mem_initialized) begin
            if (!mem.busy) begin   // init sequence finished
                mem_initialized <= 1'b1;
                busy            <= 1'b0;
            end
        end else begin
            if (cycles != 3'd7)
                cycles <= cycles + 3'd1;
            if (op_done) begin
                busy <= 1'b0;
                if (is_read && !mem.data_ready)
                    fail <= 1'b1;   // sticky, read strobe missed its slot
                if (is_write)
                    total_written <= total_written + 20'd1;
                r_read_a <= 1'b0;
                r_read_b <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cycles == 3'd4 && r_read_a)
            da <= mem.dout;
        if (cycles == 3'd4 && r_read_b)
            db <= mem.dout;
    end

endmodule

// File: hdl/sdram_top.sv
`timescale 1ns/1ps

/* sdram_top
   memory front end: user-port controller and SDRAM driver joined by one
   command interface, plain user ports and SDRAM pins */
module sdram_top import sdram_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    input  logic         read_a,
    input  logic         read_b,
    input  logic         write,
    input  logic         refresh,
    input  word_addr_t   addr,
    input  word_t        din,
    input  byte_mask_t   mask,
    output word_t        dout_a,
    output word_t        dout_b,
    output logic         busy,
    output logic         mem_initialized,
    output logic         fail,
    output logic [19:0]  total_written,

    inout  wire word_t   sdram_dq,
    output sdram_addr_t  sdram_a,
    output bank_t        sdram_ba,
    output logic         sdram_ncs,
    output logic         sdram_nras,
    output logic         sdram_ncas,
    output logic         sdram_nwe,
    output logic         sdram_cke,
    output logic [3:0]   sdram_dqm,
    output logic         sdram_clk
);

    sdram_cmd_if u_cmd_if ();

    memory_controller u_ctrl (
        .clk             (clk),
        .resetn          (resetn),
        .read_a          (read_a),
        .read_b          (read_b),
        .write           (write),
        .refresh         (refresh),
        .addr            (addr),
        .din             (din),
        .mask            (mask),
        .dout_a          (dout_a),
        .dout_b          (dout_b),
        .busy            (busy),
        .mem_initialized (mem_initialized),
        .fail            (fail),
        .total_written   (total_written),
        .mem             (u_cmd_if.controller)
    );

    sdram_driver u_drv (
        .clk        (clk),
        .resetn     (resetn),
        .cmd        (u_cmd_if.driver),
        .sdram_dq   (sdram_dq),
        .sdram_a    (sdram_a),
        .sdram_ba   (sdram_ba),
        .sdram_ncs  (sdram_ncs),
        .sdram_nras (sdram_nras),
        .sdram_ncas (sdram_ncas),
        .sdram_nwe  (sdram_nwe),
        .sdram_cke  (sdram_cke),
        .sdram_clk  (sdram_clk),
        .sdram_dqm  (sdram_dqm)
    );

endmodule

// File: verification/sdram_model.sv
`timescale 1ns/1ps

/* sdram_model
   behavioral SDR SDRAM chip: command decode, per-bank open row,
   CAS latency read return and byte-masked writes */
module sdram_model import sdram_pkg::*; (
    inout  wire word_t  sdram_dq,
    input  sdram_addr_t sdram_a,
    input  bank_t       sdram_ba,
    input  logic        sdram_ncs,
    input  logic        sdram_nras,
    input  logic        sdram_ncas,
    input  logic        sdram_nwe,
    input  logic        sdram_cke,
    input  logic [3:0]  sdram_dqm,
    input  logic        sdram_clk
);

    word_t       mem [word_addr_t];   // sparse storage, word address keyed
    logic [10:0] open_row [4];
    logic [3:0]  command;
    word_t       q;
    logic        oe;
    word_t       pend_data;
    int          pend_cnt;
    word_addr_t  key;
    sdram_addr_t mode_word;           // last word loaded by MRS

    assign command  = {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe};
    assign sdram_dq = oe ? q : 'z;

    initial begin
        oe       = 1'b0;
        pend_cnt = 0;
    end

    always @(posedge sdram_clk) begin
        oe <= 1'b0;   // read data held for one chip clock
        if (pend_cnt != 0) begin
            pend_cnt = pend_cnt - 1;
            if (pend_cnt == 0) begin
                q  <= pend_data;
                oe <= 1'b1;
            end
        end
        if (sdram_cke) begin
            key = {sdram_ba, open_row[sdram_ba], sdram_a[7:0]};
            case (command)
                CMD_ACTIVE: open_row[sdram_ba] = sdram_a;
                CMD_READ: begin
                    pend_data = mem.exists(key) ? mem[key] : 32'h0;
                    pend_cnt  = CAS_LATENCY;
                end
                CMD_WRITE: begin
                    if (!mem.exists(key))
                        mem[key] = 32'h0;
                    for (int i = 0; i < 4; i++) begin
                        if (!sdram_dqm[i])   // DQM high masks the byte
                            mem[key][i*8 +: 8] = sdram_dq[i*8 +: 8];
                    end
                end
                CMD_MRS: mode_word = sdram_a;
                default: ;   // NOP, precharge and refresh keep the data
            endcase
        end
    end

endmodule

// File: verification/tb_sdram_top.sv
`timescale 1ns/1ps

/* tb_sdram_top
   table driven test of the SDRAM front end against a behavioral chip,
   with a reference memory for expected read data */
module tb_sdram_top;
    import sdram_pkg::*;

    localparam int OP_WR     = 0;
    localparam int OP_RD     = 1;
    localparam int OP_REF    = 2;
    localparam int OP_REF_WR = 3;   // refresh plus a write that must be ignored
    localparam int N = 30;

    // single write, reserved, CAS latency, sequential, burst length 1
    localparam logic [10:0] EXP_MODE = {1'b0, 1'b1, 2'b00, 3'(CAS_LATENCY), 1'b0, 3'b000};

    logic clk, resetn, read_a, read_b, write, refresh;
    word_addr_t addr;
    word_t din, dout_a, dout_b;
    byte_mask_t mask;
    logic busy, mem_initialized, fail;
    logic [19:0] total_written;
    wire word_t sdram_dq;
    sdram_addr_t sdram_a;
    bank_t sdram_ba;
    logic sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe, sdram_cke, sdram_clk;
    logic [3:0] sdram_dqm;

    int tb_op [N];
    word_addr_t tb_addr [N];
    word_t tb_data [N];
    byte_mask_t tb_mask [N];
    logic [1:0] tb_flavor [N];   // {b, a}
    word_addr_t addr_set [8];
    word_t ref_mem [word_addr_t];
    word_t exp_a, exp_b;
    logic a_valid, b_valid;
    logic [31:0] seed;
    int n_writes;

    sdram_top UUT (.*);

    sdram_model u_chip (.*);

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR: %s expected %h got %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== 1'b0) begin
            n++;
            if (n > 50)
                stop_on_timeout("busy never went low after a command");
            @(negedge clk);
        end
    endtask

    task automatic check_read_outputs(input int k);
        if (tb_flavor[k][0] || a_valid)
            check("dout_a", tb_flavor[k][0] ? ref_mem[tb_addr[k]] : exp_a, dout_a);
        if (tb_flavor[k][1] || b_valid)
            check("dout_b", tb_flavor[k][1] ? ref_mem[tb_addr[k]] : exp_b, dout_b);
    endtask

    task automatic apply_entry(input int k);
        wait_idle();
        @(posedge clk);
        addr    <= tb_addr[k];
        din     <= tb_data[k];
        mask    <= tb_mask[k];
        read_a  <= (tb_op[k] == OP_RD) && tb_flavor[k][0];
        read_b  <= (tb_op[k] == OP_RD) && tb_flavor[k][1];
        write   <= (tb_op[k] == OP_WR);
        refresh <= (tb_op[k] == OP_REF) || (tb_op[k] == OP_REF_WR);
        @(posedge clk);   // accepting edge
        {read_a, read_b, write, refresh} <= 4'b0;
        if (tb_op[k] == OP_WR) begin
            for (int i = 0; i < 4; i++) begin
                if (tb_mask[k][i])
                    ref_mem[tb_addr[k]][i*8 +: 8] = tb_data[k][i*8 +: 8];
            end
            n_writes++;
        end else if (tb_op[k] == OP_RD) begin
            repeat (4) @(posedge clk);
            @(negedge clk);
            check("busy", 1, busy);
            check_read_outputs(k);   // cycle 4, bypassed data
            @(negedge clk);
            check("busy", 0, busy);
            check_read_outputs(k);   // registered value holds
            if (tb_flavor[k][0]) begin
                exp_a   = ref_mem[tb_addr[k]];
                a_valid = 1'b1;
            end
            if (tb_flavor[k][1]) begin
                exp_b   = ref_mem[tb_addr[k]];
                b_valid = 1'b1;
            end
        end else begin
            @(posedge clk);
            if (tb_op[k] == OP_REF_WR) begin
                write <= 1'b1;   // must be dropped while busy
                din   <= ~tb_data[k];
                mask  <= 4'hf;
            end
            @(posedge clk);
            write <= 1'b0;
            repeat (2) @(posedge clk);
            @(negedge clk);
            check("busy", 1, busy);
            @(negedge clk);
            check("busy", 0, busy);
        end
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        {read_a, read_b, write, refresh} = 4'b0;
        addr = '0;
        din = '0;
        mask = '0;
        seed = 32'h5db01ac0;
        n_writes = 0;
        a_valid = 1'b0;
        b_valid = 1'b0;

        for (int i = 0; i < 8; i++)   // two addresses per bank
            addr_set[i] = {2'(i % 4), 19'(lcg_next() >> 7)};
        for (int k = 0; k < N; k++) begin
            tb_addr[k]   = addr_set[k % 8];
            tb_data[k]   = lcg_next();
            tb_mask[k]   = 4'hf;
            tb_flavor[k] = 2'b01;
            if (k < 8) begin
                tb_op[k] = OP_WR;
            end else if (k < 16) begin
                tb_op[k]     = OP_RD;
                tb_flavor[k] = (k < 12) ? 2'b01 : (k < 14) ? 2'b10 : 2'b11;
            end else if (k < 20) begin
                tb_op[k]   = OP_WR;
                tb_mask[k] = 4'(lcg_next() >> 12);
            end else if (k == 20) begin
                tb_op[k] = OP_REF_WR;
            end else if (k == 21) begin
                tb_op[k] = OP_REF;
            end else begin
                tb_op[k]     = OP_RD;
                tb_flavor[k] = 2'(k % 3 + 1);
            end
        end

        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check("busy", 1, busy);
        check("mem_initialized", 0, mem_initialized);
        for (int n = 0; mem_initialized !== 1'b1; n++) begin
            if (n > INIT_WAIT_CYCLES + 100)
                stop_on_timeout("mem_initialized never went high");
            @(negedge clk);
        end
        check("busy", 0, busy);
        check("fail", 0, fail);
        check("sdram mode word", EXP_MODE, u_chip.mode_word);

        for (int k = 0; k < N; k++)
            apply_entry(k);

        wait_idle();
        check("total_written", n_writes, total_written);
        check("fail", 0, fail);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: build.f
hdl/sdram_pkg.sv
hdl/sdram_cmd_if.sv
hdl/sdram_driver.sv
hdl/memory_controller.sv
hdl/sdram_top.sv
verification/sdram_model.sv
verification/tb_sdram_top.sv
